// ==== core_reg_file_ff.sv ====
// Flip-flop register file with two combinational read ports and one write port.
// Runs on the gated core clock. Writes to x0 are dropped and x0 always reads ZeroWord.
// With RV32E only x1..x15 exist; other addresses read ZeroWord and ignore writes.
`timescale 1ns/1ps

module core_reg_file_ff #(
  parameter bit RV32E = 1'b0
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  input  logic [core_shell_pkg::RegAddrW-1:0] raddr_a_i,
  input  logic [core_shell_pkg::RegAddrW-1:0] raddr_b_i,

  input  logic [core_shell_pkg::RegAddrW-1:0] waddr_i,
  input  logic                                we_i,
  input  logic [core_shell_pkg::WordW-1:0]    wdata_i,

  output logic [core_shell_pkg::WordW-1:0]    rdata_a_o,
  output logic [core_shell_pkg::WordW-1:0]    rdata_b_o
);

  localparam int unsigned NumRegs = RV32E ? 16 : 32;
  localparam int unsigned NumAddr = 2 ** core_shell_pkg::RegAddrW;

  // x0 has no storage
  logic [core_shell_pkg::WordW-1:0] rf_q   [1:NumRegs-1];
  logic [NumRegs-1:1]               we_dec;

  // Every address slot, with ZeroWord where no register exists
  logic [core_shell_pkg::WordW-1:0] rf_all [NumAddr];

  //////////////////////////////
  // Write decode
  //////////////////////////////

  // Addresses at or above NumRegs never match any enable
  for (genvar i = 1; i < NumRegs; i++) begin : g_we_dec
    assign we_dec[i] = we_i & (waddr_i == core_shell_pkg::RegAddrW'(i));
  end

  //////////////////////////////
  // Storage
  //////////////////////////////

  for (genvar i = 1; i < NumRegs; i++) begin : g_rf_flops
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= core_shell_pkg::ZeroWord;
      end else if (we_dec[i]) begin
        rf_q[i] <= wdata_i;
      end
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////

  for (genvar i = 0; i < NumAddr; i++) begin : g_rf_all
    if (i == 0 || i >= NumRegs) begin : g_zero
      assign rf_all[i] = core_shell_pkg::ZeroWord;
    end else begin : g_reg
      assign rf_all[i] = rf_q[i];
    end
  end

  // Address width covers every slot, so no range check is needed here
  assign rdata_a_o = rf_all[raddr_a_i];
  assign rdata_b_o = rf_all[raddr_b_i];

endmodule

// ==== core_rf_intg_check.sv ====
// Integrity check on both register file read words.
// Purely combinational; the alert follows the read addresses without delay.
// It flags any word whose stored integrity disagrees with its data bits.
`timescale 1ns/1ps

module core_rf_intg_check (
  input  logic [core_shell_pkg::WordW-1:0] rdata_a_i,
  input  logic [core_shell_pkg::WordW-1:0] rdata_b_i,

  output logic                             alert_major_internal_o
);

  localparam int unsigned NumPorts = 2;

  logic [core_shell_pkg::WordW-1:0] rdata      [NumPorts];
  logic [core_shell_pkg::DataW-1:0] data       [NumPorts];
  logic [core_shell_pkg::IntgW-1:0] intg_rd    [NumPorts];
  logic [core_shell_pkg::IntgW-1:0] intg_exp   [NumPorts];
  logic [NumPorts-1:0]              intg_err;

  assign rdata[0] = rdata_a_i;
  assign rdata[1] = rdata_b_i;

  //////////////////////////////
  // Per-port check
  //////////////////////////////

  for (genvar p = 0; p < NumPorts; p++) begin : g_port
    // Split the stored word into data and integrity fields
    assign data[p]    = rdata[p][core_shell_pkg::DataW-1:0];
    assign intg_rd[p] = rdata[p][core_shell_pkg::WordW-1:core_shell_pkg::DataW];

    // Recompute from the data bits
    assign intg_exp[p] = core_shell_pkg::intg_calc(data[p]);

    assign intg_err[p] = (intg_rd[p] != intg_exp[p]);
  end

  // Either port failing is a major fault
  assign alert_major_internal_o = |intg_err;

endmodule

// ==== core_shell_pkg.sv ====
// Shared widths, busy code and register word integrity for the core shell.
// A stored word is {integrity[6:0], data[31:0]}. The integrity is a folded parity,
// not a SECDED code. It detects corruption but cannot correct it.

package core_shell_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  parameter int unsigned DataW    = 32;
  parameter int unsigned IntgW    = 7;
  parameter int unsigned WordW    = DataW + IntgW;
  parameter int unsigned RegAddrW = 5;

  //////////////////////////////
  // Busy code
  //////////////////////////////

  // Multi-bit code so that a single flipped bit cannot put the core to sleep
  typedef logic [3:0] busy_code_t;

  parameter busy_code_t BusyOff = 4'b1010;
  parameter busy_code_t BusyOn  = 4'b0101;

  //////////////////////////////
  // Integrity
  //////////////////////////////

  // Inverted so an all-zero word is never valid
  parameter logic [IntgW-1:0] IntgInvMask = 7'h03;

  // Value of x0 and the reset value of every register
  parameter logic [WordW-1:0] ZeroWord = {IntgInvMask, {DataW{1'b0}}};

  // Bit k is the parity of the data bits with index mod 7 equal to k
  function automatic logic [IntgW-1:0] intg_calc(input logic [DataW-1:0] data);
    logic [IntgW-1:0] intg;
    intg = '0;
    for (int i = 0; i < DataW; i++) begin
      intg[i % IntgW] = intg[i % IntgW] ^ data[i];
    end
    return intg ^ IntgInvMask;
  endfunction

endpackage

// ==== core_shell_top.sv ====
// Support shell around the core: sleep control, register file and integrity check.
// The core itself is external and drives the register file ports directly.
// Write data must already carry its integrity bits.
`timescale 1ns/1ps

module core_shell_top #(
  parameter bit RV32E = 1'b0
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Forces the core clock gate open
  input  logic                                test_en_i,

  // Sleep and wake sources
  input  core_shell_pkg::busy_code_t          core_busy_i,
  input  logic                                debug_req_i,
  input  logic                                irq_pending_i,
  input  logic                                irq_nm_i,

  // Register file read ports
  input  logic [core_shell_pkg::RegAddrW-1:0] rf_raddr_a_i,
  input  logic [core_shell_pkg::RegAddrW-1:0] rf_raddr_b_i,
  output logic [core_shell_pkg::WordW-1:0]    rf_rdata_a_o,
  output logic [core_shell_pkg::WordW-1:0]    rf_rdata_b_o,

  // Register file write port
  input  logic [core_shell_pkg::RegAddrW-1:0] rf_waddr_i,
  input  logic                                rf_we_i,
  input  logic [core_shell_pkg::WordW-1:0]    rf_wdata_i,

  // Status
  output logic                                core_sleep_o,
  output logic                                alert_major_internal_o
);

  logic clk_gated;

  //////////////////////////////
  // Sleep control
  //////////////////////////////

  core_sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .test_en_i    (test_en_i),
    .clk_gated_o  (clk_gated),
    .core_sleep_o (core_sleep_o)
  );

  //////////////////////////////
  // Register file
  //////////////////////////////

  // Clocked by the gated clock, so writes while asleep are lost
  core_reg_file_ff #(
    .RV32E(RV32E)
  ) u_reg_file (
    .clk_i    (clk_gated),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .waddr_i  (rf_waddr_i),
    .we_i     (rf_we_i),
    .wdata_i  (rf_wdata_i),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o)
  );

  //////////////////////////////
  // Integrity check
  //////////////////////////////

  // Checks the same words the core sees
  core_rf_intg_check u_intg_check (
    .rdata_a_i             (rf_rdata_a_o),
    .rdata_b_i             (rf_rdata_b_o),
    .alert_major_internal_o(alert_major_internal_o)
  );

endmodule

// ==== core_sleep_ctrl.sv ====
// Sleep control and core clock gate.
// The busy code is sampled on the free-running clock and must equal BusyOff to sleep.
// Any other pattern, valid or not, keeps the clock running.
`timescale 1ns/1ps

module core_sleep_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  core_shell_pkg::busy_code_t core_busy_i,
  input  logic                      debug_req_i,
  input  logic                      irq_pending_i,
  input  logic                      irq_nm_i,
  input  logic                      test_en_i,

  output logic                      clk_gated_o,
  output logic                      core_sleep_o
);

  core_shell_pkg::busy_code_t core_busy_q;
  logic                       wake;
  logic                       gate_en;
  logic                       gate_en_latch;

  //////////////////////////////
  // Busy register
  //////////////////////////////

  // Full pattern is kept, not just one bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= core_shell_pkg::BusyOff;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Level inputs wake the core in the same cycle
  assign wake = (core_busy_q != core_shell_pkg::BusyOff) |
                debug_req_i                               |
                irq_pending_i                             |
                irq_nm_i;

  assign core_sleep_o = ~wake;

  //////////////////////////////
  // Clock gate
  //////////////////////////////

  // Test mode forces the gate open
  assign gate_en = wake | test_en_i;

  // Transparent while the clock is low, so the enable is stable across the high phase
  always_latch begin
    if (!clk_i) begin
      gate_en_latch = gate_en;
    end
  end

  assign clk_gated_o = clk_i & gate_en_latch;

endmodule

// ==== sources.f ====
core_shell_pkg.sv
core_sleep_ctrl.sv
core_reg_file_ff.sv
core_rf_intg_check.sv
core_shell_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_core_shell.sv

// ==== tb_checker.sv ====
// Compares the DUT outputs with the expected values from the testbench model.
// Samples on the falling clock edge, half a cycle after the inputs change.
`timescale 1ns/1ps

module tb_checker (
  input  logic                             clk_i,
  input  logic                             chk_en_i,

  input  logic                             exp_sleep_i,
  input  logic                             exp_alert_i,
  input  logic [core_shell_pkg::WordW-1:0] exp_rdata_a_i,
  input  logic [core_shell_pkg::WordW-1:0] exp_rdata_b_i,

  input  logic                             core_sleep_i,
  input  logic                             alert_i,
  input  logic [core_shell_pkg::WordW-1:0] rdata_a_i,
  input  logic [core_shell_pkg::WordW-1:0] rdata_b_i,

  output int unsigned                      err_cnt_o
);

  int unsigned chk_cnt;
  int unsigned test_err;
  int unsigned test_cnt;
  int unsigned test_fail;

  initial begin
    err_cnt_o = 0;
    chk_cnt   = 0;
    test_err  = 0;
    test_cnt  = 0;
    test_fail = 0;
  end

  task automatic compare(input string name,
                         input logic [core_shell_pkg::WordW-1:0] got,
                         input logic [core_shell_pkg::WordW-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("[FAIL] %s at %0t: got %h expected %h", name, $time, got, exp);
      err_cnt_o++;
      test_err++;
    end
  endtask

  always @(negedge clk_i) begin
    if (chk_en_i) begin
      compare("core_sleep_o", core_shell_pkg::WordW'(core_sleep_i),
              core_shell_pkg::WordW'(exp_sleep_i));
      compare("alert_major_internal_o", core_shell_pkg::WordW'(alert_i),
              core_shell_pkg::WordW'(exp_alert_i));
      compare("rf_rdata_a_o", rdata_a_i, exp_rdata_a_i);
      compare("rf_rdata_b_o", rdata_b_i, exp_rdata_b_i);
    end
  end

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic report_test(input string name);
    test_cnt++;
    if (test_err == 0) begin
      $display("PASS  %s", name);
    end else begin
      test_fail++;
      $display("FAIL  %s (%0d mismatches)", name, test_err);
    end
    test_err = 0;
  endtask

  task automatic report_summary();
    $display("Tests run %0d, failed %0d; checks %0d, mismatches %0d",
             test_cnt, test_fail, chk_cnt, err_cnt_o);
  endtask

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and reset source.
// Reset is asserted shortly after time zero and released on a rising edge.
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real         PeriodNs    = 8.0,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

  // Start high so the falling edge reaches every flop
  initial begin
    rst_no = 1'b1;
    #1;
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== tb_core_shell.sv ====
// Testbench for the core shell. Stands in for the core and drives every DUT input
// on the rising clock edge. A register model predicts reads, sleep and alert.
// Built for RV32E = 0; the model follows the parameter for the register count.
`timescale 1ns/1ps

module tb_core_shell;

  localparam bit          RV32E     = 1'b0;
  localparam int unsigned NumRegs   = RV32E ? 16 : 32;
  localparam int unsigned DataW     = core_shell_pkg::DataW;
  localparam int unsigned WordW     = core_shell_pkg::WordW;
  localparam int unsigned RegAddrW  = core_shell_pkg::RegAddrW;
  localparam int unsigned MaxCycles = 2000;

  logic clk;
  logic rst_n;

  // DUT inputs
  core_shell_pkg::busy_code_t busy_d;
  logic                       dbg_d;
  logic                       irq_d;
  logic                       nmi_d;
  logic                       ten_d;
  logic                       we_d;
  logic [RegAddrW-1:0]        ra_d;
  logic [RegAddrW-1:0]        rb_d;
  logic [RegAddrW-1:0]        wa_d;
  logic [WordW-1:0]           wd_d;

  // DUT outputs
  logic [WordW-1:0] rdata_a;
  logic [WordW-1:0] rdata_b;
  logic             core_sleep;
  logic             alert;

  // Values for the next cycle, set by the test sequence
  core_shell_pkg::busy_code_t nx_busy;
  logic                       nx_dbg;
  logic                       nx_irq;
  logic                       nx_nmi;
  logic                       nx_ten;
  logic                       nx_we;
  logic [RegAddrW-1:0]        nx_ra;
  logic [RegAddrW-1:0]        nx_rb;
  logic [RegAddrW-1:0]        nx_wa;
  logic [WordW-1:0]           nx_wd;
  logic                       nx_corrupt;

  // Expected values and model state
  logic                       chk_en;
  logic                       exp_sleep;
  logic                       exp_alert;
  logic [WordW-1:0]           exp_a;
  logic [WordW-1:0]           exp_b;
  logic [WordW-1:0]           model [32];
  logic                       corrupt_d;
  logic                       corrupt_m [32];
  core_shell_pkg::busy_code_t busy_q_m;
  logic [31:0]                rng;
  logic                       timed_out;
  int unsigned                err_cnt;

  tb_clk_gen #(
    .PeriodNs   (8.0),
    .ResetCycles(5)
  ) u_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  core_shell_top #(
    .RV32E(RV32E)
  ) u_dut (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .test_en_i             (ten_d),
    .core_busy_i           (busy_d),
    .debug_req_i           (dbg_d),
    .irq_pending_i         (irq_d),
    .irq_nm_i              (nmi_d),
    .rf_raddr_a_i          (ra_d),
    .rf_raddr_b_i          (rb_d),
    .rf_rdata_a_o          (rdata_a),
    .rf_rdata_b_o          (rdata_b),
    .rf_waddr_i            (wa_d),
    .rf_we_i               (we_d),
    .rf_wdata_i            (wd_d),
    .core_sleep_o          (core_sleep),
    .alert_major_internal_o(alert)
  );

  tb_checker u_chk (
    .clk_i        (clk),
    .chk_en_i     (chk_en),
    .exp_sleep_i  (exp_sleep),
    .exp_alert_i  (exp_alert),
    .exp_rdata_a_i(exp_a),
    .exp_rdata_b_i(exp_b),
    .core_sleep_i (core_sleep),
    .alert_i      (alert),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .err_cnt_o    (err_cnt)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [WordW-1:0] make_word(input logic [DataW-1:0] d);
    return {core_shell_pkg::intg_calc(d), d};
  endfunction

  // x0 and missing registers read as the zero word
  function automatic logic [WordW-1:0] ref_word(input logic [RegAddrW-1:0] addr);
    if (addr == '0 || addr >= NumRegs) begin
      return core_shell_pkg::ZeroWord;
    end
    return model[addr];
  endfunction

  function automatic logic ref_sleep(input core_shell_pkg::busy_code_t busy_q,
                                     input logic dbg, input logic irq, input logic nmi);
    return !((busy_q != core_shell_pkg::BusyOff) || dbg || irq || nmi);
  endfunction

  // High only where a deliberately corrupted word sits behind a read port
  function automatic logic ref_alert(input logic [RegAddrW-1:0] ra,
                                     input logic [RegAddrW-1:0] rb);
    return corrupt_m[ra] || corrupt_m[rb];
  endfunction

  // One clock cycle: settle the model for this edge, then drive the next inputs
  task automatic step();
    logic gate_open;
    @(posedge clk);
    gate_open = (busy_q_m != core_shell_pkg::BusyOff) || dbg_d || irq_d || nmi_d || ten_d;
    if (gate_open && we_d && wa_d != '0 && wa_d < NumRegs) begin
      model[wa_d]     = wd_d;
      corrupt_m[wa_d] = corrupt_d;
    end
    busy_q_m = busy_d;
    busy_d    <= nx_busy;
    dbg_d     <= nx_dbg;
    irq_d     <= nx_irq;
    nmi_d     <= nx_nmi;
    ten_d     <= nx_ten;
    we_d      <= nx_we;
    ra_d      <= nx_ra;
    rb_d      <= nx_rb;
    wa_d      <= nx_wa;
    wd_d      <= nx_wd;
    corrupt_d <= nx_corrupt;
    exp_sleep <= ref_sleep(busy_q_m, nx_dbg, nx_irq, nx_nmi);
    exp_a     <= ref_word(nx_ra);
    exp_b     <= ref_word(nx_rb);
    exp_alert <= ref_alert(nx_ra, nx_rb);
    chk_en    <= 1'b1;
  endtask

  task automatic rand_reads();
    rng   = lcg_next(rng);
    nx_ra = rng[28:24];
    rng   = lcg_next(rng);
    nx_rb = rng[28:24];
  endtask

  task automatic write_reg(input logic [RegAddrW-1:0] addr, input logic [WordW-1:0] word);
    nx_we = 1'b1;
    nx_wa = addr;
    nx_wd = word;
    step();
    nx_we = 1'b0;
  endtask

  // Let the last cycle be checked before reporting
  task automatic finish_test(input string name);
    @(negedge clk);
    #1;
    u_chk.report_test(name);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    logic [RegAddrW-1:0] addr;
    logic [RegAddrW-1:0] other;
    logic [WordW-1:0]    word;
    logic [WordW-1:0]    bad;
    logic [RegAddrW-1:0] addr_q [8];
    logic [WordW-1:0]    word_q [8];
    int unsigned         cnt;

    busy_d    <= core_shell_pkg::BusyOff;
    dbg_d     <= 1'b0;
    irq_d     <= 1'b0;
    nmi_d     <= 1'b0;
    ten_d     <= 1'b0;
    we_d      <= 1'b0;
    ra_d      <= '0;
    rb_d      <= '0;
    wa_d      <= '0;
    wd_d      <= '0;
    corrupt_d <= 1'b0;
    chk_en    <= 1'b0;
    exp_sleep <= 1'b1;
    exp_alert <= 1'b0;
    exp_a     <= core_shell_pkg::ZeroWord;
    exp_b     <= core_shell_pkg::ZeroWord;
    nx_busy   = core_shell_pkg::BusyOff;
    nx_dbg    = 1'b0;
    nx_irq    = 1'b0;
    nx_nmi    = 1'b0;
    nx_ten    = 1'b0;
    nx_we     = 1'b0;
    nx_ra     = '0;
    nx_rb     = '0;
    nx_wa     = '0;
    nx_wd     = '0;
    nx_corrupt = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model[i]     = core_shell_pkg::ZeroWord;
      corrupt_m[i] = 1'b0;
    end
    busy_q_m  = core_shell_pkg::BusyOff;
    rng       = 32'hae29f99a;
    timed_out = 1'b0;

    // Reset goes low first, then high again on a rising edge
    cnt = 0;
    while (rst_n !== 1'b0 && cnt < 20) begin
      @(posedge clk);
      cnt++;
    end
    if (rst_n !== 1'b0) begin
      timed_out = 1'b1;
      $display("Timeout: reset was never asserted");
    end

    cnt = 0;
    while (!timed_out && rst_n !== 1'b1 && cnt < 20) begin
      @(posedge clk);
      cnt++;
    end
    if (!timed_out && rst_n !== 1'b1) begin
      timed_out = 1'b1;
      $display("Timeout: reset was never released");
    end

    if (!timed_out) begin
      // Reset state
      for (int i = 0; i < 8; i++) begin
        rand_reads();
        step();
      end
      finish_test("reset state");

      // Wake rules
      nx_ra   = '0;
      nx_rb   = '0;
      nx_busy = core_shell_pkg::BusyOn;
      step();
      step();
      nx_busy = core_shell_pkg::BusyOff;
      repeat (3) step();
      nx_dbg = 1'b1;
      step();
      nx_dbg = 1'b0;
      step();
      nx_irq = 1'b1;
      step();
      nx_irq = 1'b0;
      step();
      nx_nmi = 1'b1;
      step();
      nx_nmi = 1'b0;
      step();
      // Invalid code counts as busy
      nx_busy = 4'b1111;
      repeat (2) step();
      nx_busy = core_shell_pkg::BusyOff;
      repeat (2) step();
      finish_test("wake rules");

      // Write and read-back while busy
      nx_busy = core_shell_pkg::BusyOn;
      step();
      for (int i = 0; i < 24; i++) begin
        rng  = lcg_next(rng);
        addr = rng[28:24];
        rng  = lcg_next(rng);
        rand_reads();
        write_reg(addr, make_word(rng));
        nx_ra = addr;
        step();
      end
      write_reg('0, make_word(32'hffff_ffff));
      nx_ra = '0;
      nx_rb = '0;
      step();
      finish_test("write and read-back");

      // Writes while asleep, then the same writes in test mode
      nx_busy = core_shell_pkg::BusyOff;
      repeat (3) step();
      for (int i = 0; i < 8; i++) begin
        rng       = lcg_next(rng);
        addr_q[i] = rng[28:24];
        rng       = lcg_next(rng);
        word_q[i] = make_word(rng);
        write_reg(addr_q[i], word_q[i]);
        nx_ra = addr_q[i];
        step();
      end
      nx_ten = 1'b1;
      for (int i = 0; i < 8; i++) begin
        write_reg(addr_q[i], word_q[i]);
        nx_ra = addr_q[i];
        nx_rb = addr_q[i];
        step();
      end
      nx_ten = 1'b0;
      step();
      finish_test("writes while asleep");

      // Integrity alert
      nx_busy = core_shell_pkg::BusyOn;
      step();
      rng  = lcg_next(rng);
      addr = rng[28:24];
      if (addr == '0) begin
        addr = 5'd1;
      end
      other = addr ^ 5'd1;
      rng   = lcg_next(rng);
      word  = make_word(rng);
      bad   = word;
      bad[DataW + 4] = ~bad[DataW + 4];
      nx_ra = other;
      nx_rb = other;
      nx_corrupt = 1'b1;
      write_reg(addr, bad);
      nx_corrupt = 1'b0;
      nx_ra = addr;
      step();
      nx_ra = other;
      nx_rb = addr;
      step();
      nx_rb = other;
      step();
      write_reg(addr, word);
      nx_ra = addr;
      nx_rb = addr;
      step();
      finish_test("integrity alert");
    end

    u_chk.report_summary();
    if (err_cnt == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Guards the whole run against a stalled sequence
  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: test sequence did not finish within %0d cycles", MaxCycles);
    $display("Simulation failed");
    $finish;
  end

endmodule
